// File: common/vid_pkg.sv
// video controller definitions
`default_nettype none

package vid_pkg;

typedef logic [15:0] word_t;            // cpu and vram data word
typedef logic [15:0] addr_t;            // vram or xr address

typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
} rgb_t;                                // 4:4:4 colour

typedef logic [4:0] hcount_t;           // covers H_TOTAL
typedef logic [3:0] vcount_t;           // covers V_TOTAL

localparam int VRAM_AW          = 10;   // 1024 words

// tiny fixed video mode
localparam int H_VISIBLE        = 16;
localparam int H_TOTAL          = 24;
localparam int V_VISIBLE        = 8;
localparam int V_TOTAL          = 12;
localparam int HSYNC_START      = 18;
localparam int HSYNC_END        = 21;   // first pixel after hsync
localparam int VSYNC_LINE       = 9;
localparam int WORDS_PER_LINE   = 4;    // 16 pixels at 4 bpp

// cpu bus register numbers
localparam logic [3:0] REG_VRAM_WADDR   = 4'd0;
localparam logic [3:0] REG_VRAM_DATA    = 4'd1;
localparam logic [3:0] REG_VRAM_RADDR   = 4'd2;
localparam logic [3:0] REG_VRAM_RDATA   = 4'd3;
localparam logic [3:0] REG_XR_ADDR      = 4'd4;
localparam logic [3:0] REG_XR_DATA      = 4'd5;
localparam logic [3:0] REG_INT          = 4'd6;

// xr register map
localparam logic [7:0] XR_START_ADDR    = 8'h00;
localparam logic [7:0] XR_PALETTE_BASE  = 8'h10;    // 16 entries up to 0x1F

// interrupt vector bits
localparam int INT_VBLANK       = 0;

endpackage

`default_nettype wire

// File: common/vram_port_if.sv
// cpu side vram port
`default_nettype none
`timescale 1ns/1ns

interface vram_port_if;
    logic               sel;        // held until ack
    logic               wr;         // 1 write, 0 read
    vid_pkg::addr_t     addr;
    vid_pkg::word_t     wdata;
    logic               ack;        // one cycle pulse
    vid_pkg::word_t     rdata;      // valid with ack

    modport req (
        output sel,
        output wr,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport mem (
        input  sel,
        input  wr,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );
endinterface

`default_nettype wire

// File: common/xr_bus_if.sv
// xr configuration bus
`default_nettype none
`timescale 1ns/1ns

interface xr_bus_if;
    logic               wr;         // write strobe, one cycle
    logic [7:0]         addr;       // xr register number
    vid_pkg::word_t     wdata;
    vid_pkg::word_t     rdata;      // combinational from addr

    modport ctrl (
        output wr,
        output addr,
        output wdata,
        input  rdata
    );

    modport periph (
        input  wr,
        input  addr,
        input  wdata,
        output rdata
    );
endinterface

`default_nettype wire

// File: dv/vid_main_assert.sv
// bus and video timing assertions
`default_nettype none
`timescale 1ns/1ns

module vid_main_assert (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           sel_i,      // cpu vram select
    input  wire logic           ack_i,
    input  wire logic           intr_i,
    input  wire logic [3:0]     red_i,
    input  wire logic [3:0]     green_i,
    input  wire logic [3:0]     blue_i,
    input  wire logic           de_i
);

int assert_failures = 0;    // failed assertions so far

// request stays up until the arbiter answers
sel_held: assert property (@(posedge clk) disable iff (reset_i)
    (sel_i && !ack_i) |=> sel_i)
    else begin
        assert_failures++;
        $error("vram select dropped before ack");
    end

// strobe only
intr_single: assert property (@(posedge clk) disable iff (reset_i)
    intr_i |=> !intr_i)
    else begin
        assert_failures++;
        $error("interrupt line high for two cycles");
    end

rgb_blank: assert property (@(posedge clk) disable iff (reset_i)
    !de_i |-> ({red_i, green_i, blue_i} == 12'h000))
    else begin
        assert_failures++;
        $error("colour output not black in blanking");
    end

endmodule

bind vid_main vid_main_assert i_assert (
    .clk        (clk),
    .reset_i    (reset_i),
    .sel_i      (vram_port.sel),
    .ack_i      (vram_port.ack),
    .intr_i     (bus_intr_o),
    .red_i      (red_o),
    .green_i    (green_o),
    .blue_i     (blue_o),
    .de_i       (dv_de_o)
);

`default_nettype wire

// File: dv/vid_main_tb.sv
// video controller testbench
`default_nettype none
`timescale 1ns/1ns

module vid_main_tb;

localparam int FRAME_CYCLES = vid_pkg::H_TOTAL * vid_pkg::V_TOTAL;
localparam int PIXELS       = vid_pkg::H_VISIBLE * vid_pkg::V_VISIBLE;
localparam int POLL_LIMIT   = 64;       // busy polls per access

logic           clk;
logic           reset_i;
logic           bus_cs_n;
logic           bus_rd_nwr;
logic [3:0]     bus_reg_num;
logic           bus_bytesel;
logic [7:0]     bus_wdata;
logic [7:0]     bus_rdata;
logic           bus_intr;
logic [3:0]     red;
logic [3:0]     green;
logic [3:0]     blue;
logic           hsync;
logic           vsync;
logic           dv_de;

logic [15:0]    ref_vram [0:1023];      // model of what the cpu wrote
logic [11:0]    ref_pal [0:15];
logic [15:0]    ref_start;
logic [31:0]    rng;
string          cur_test;
int             tests;
int             checks;
int             errors;
int             test_checks;            // snapshots at test start
int             test_errors;
int             intr_count;
int             de_count;               // enabled pixels since vsync
int             raster_h;               // output position of the raster
int             raster_v;
logic           vsync_q;
logic           check_req;              // set by main, cleared by compare
logic           check_armed;

vid_main i_dut (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n),
    .bus_rd_nwr_i   (bus_rd_nwr),
    .bus_reg_num_i  (bus_reg_num),
    .bus_bytesel_i  (bus_bytesel),
    .bus_data_i     (bus_wdata),
    .bus_data_o     (bus_rdata),
    .bus_intr_o     (bus_intr),
    .red_o          (red),
    .green_o        (green),
    .blue_o         (blue),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .dv_de_o        (dv_de)
);

always #5 clk = ~clk;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// colour of visible pixel x,y from the model
function automatic logic [11:0] expected_pixel(input int x, input int y);
    logic [15:0] addr;
    logic [15:0] word;
    logic [3:0]  index;
    addr  = ref_start + 16'(y * vid_pkg::WORDS_PER_LINE + x / 4);
    word  = ref_vram[addr[vid_pkg::VRAM_AW-1:0]];   // array wraps at 1k
    index = word[15 - 4 * (x % 4) -: 4];            // leftmost pixel in top nibble
    return ref_pal[index];
endfunction

// hsync, vsync and enable at raster position h,v
function automatic logic [2:0] expected_sync(input int h, input int v);
    logic hs;
    logic vs;
    logic de;
    hs = (h >= vid_pkg::HSYNC_START) && (h < vid_pkg::HSYNC_END);
    vs = (v == vid_pkg::VSYNC_LINE);                // one whole line
    de = (h < vid_pkg::H_VISIBLE) && (v < vid_pkg::V_VISIBLE);
    return {hs, vs, de};
endfunction

task automatic random_word(output logic [15:0] w);
    rng = xorshift32(rng);
    w   = rng[23:8];
endtask

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $finish;
endtask

task automatic check_value(input string what, input logic [15:0] expected,
                           input logic [15:0] actual);
    checks++;
    assert (actual === expected) else begin
        $display("error %s %s: expected %h, actual %h", cur_test, what, expected, actual);
        errors++;
    end
endtask

task automatic begin_test(input string name);
    cur_test    = name;
    test_checks = checks;
    test_errors = errors;
endtask

task automatic end_test();
    tests++;
    $display("test %s done: %0d checks, %0d errors", cur_test,
             checks - test_checks, errors - test_errors);
endtask

// one cs low period per byte, high again before the next
task automatic write_byte(input logic [3:0] reg_num, input logic odd, input logic [7:0] data);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= 1'b0;
    bus_reg_num <= reg_num;
    bus_bytesel <= odd;
    bus_wdata   <= data;
    @(posedge clk);
    bus_cs_n    <= 1'b1;
    bus_rd_nwr  <= 1'b1;
endtask

task automatic read_byte(input logic [3:0] reg_num, input logic odd, output logic [7:0] data);
    @(posedge clk);
    bus_cs_n    <= 1'b0;
    bus_rd_nwr  <= 1'b1;
    bus_reg_num <= reg_num;
    bus_bytesel <= odd;
    @(posedge clk);
    @(negedge clk);
    data = bus_rdata;               // second cycle of the low period
    @(posedge clk);
    bus_cs_n    <= 1'b1;
endtask

task automatic write_word(input logic [3:0] reg_num, input logic [15:0] w);
    write_byte(reg_num, 1'b0, w[15:8]);
    write_byte(reg_num, 1'b1, w[7:0]);      // odd byte fires the action
endtask

task automatic read_word(input logic [3:0] reg_num, output logic [15:0] w);
    logic [7:0] hi;
    logic [7:0] lo;
    read_byte(reg_num, 1'b0, hi);
    read_byte(reg_num, 1'b1, lo);
    w = {hi, lo};
endtask

task automatic wait_not_busy();
    logic [7:0] status;
    int         polls;
    polls  = 0;
    status = 8'h80;
    while (status[7] && polls < POLL_LIMIT) begin
        read_byte(vid_pkg::REG_INT, 1'b1, status);  // busy is bit 7
        polls++;
    end
    if (status[7]) begin
        abort_run("vram access still busy after the polling limit");
    end
endtask

task automatic write_xr(input logic [7:0] addr, input logic [15:0] w);
    write_word(vid_pkg::REG_XR_ADDR, {8'h00, addr});
    write_word(vid_pkg::REG_XR_DATA, w);
endtask

task automatic read_xr(input logic [7:0] addr, output logic [15:0] w);
    write_word(vid_pkg::REG_XR_ADDR, {8'h00, addr});
    read_word(vid_pkg::REG_XR_DATA, w);
endtask

task automatic fill_vram(input logic [15:0] base, input int count);
    logic [15:0] w;
    logic [15:0] a;
    int          i;
    write_word(vid_pkg::REG_VRAM_WADDR, base);
    for (i = 0; i < count; i++) begin
        random_word(w);
        write_word(vid_pkg::REG_VRAM_DATA, w);
        wait_not_busy();
        a = base + 16'(i);                          // auto increment
        ref_vram[a[vid_pkg::VRAM_AW-1:0]] = w;
    end
endtask

task automatic read_vram(input logic [15:0] addr, output logic [15:0] w);
    write_word(vid_pkg::REG_VRAM_RADDR, addr);
    wait_not_busy();
    read_word(vid_pkg::REG_VRAM_RDATA, w);
endtask

task automatic wait_frames(input int n);
    int   seen;
    int   cycles;
    logic prev;
    seen   = 0;
    cycles = 0;
    prev   = vsync;
    while (seen < n && cycles < (n + 1) * FRAME_CYCLES) begin
        @(negedge clk);
        if (vsync && !prev) begin
            seen++;
        end
        prev = vsync;
        cycles++;
    end
    if (seen < n) begin
        abort_run("no vertical sync seen within the expected time");
    end
endtask

// compare process picks up the next whole frame
task automatic check_frame();
    int cycles;
    cycles    = 0;
    check_req = 1'b1;
    while (check_req && cycles < 3 * FRAME_CYCLES) begin
        @(posedge clk);
        cycles++;
    end
    if (check_req) begin
        abort_run("checked frame did not complete in time");
    end
endtask

always @(negedge clk) begin
    if (bus_intr) begin
        intr_count++;
    end
end

// frame compare, de cycles counted from vsync
always @(negedge clk) begin : compare_frame
    int x;
    int y;
    if (vsync && !vsync_q) begin
        if (check_req) begin
            assert (!check_armed) else begin
                $display("%s: frame ended after %0d of %0d pixels", cur_test,
                         de_count, PIXELS);
                errors++;
            end
            check_armed = 1'b1;
            raster_h    = 0;                        // vsync rises at h 0
            raster_v    = vid_pkg::VSYNC_LINE;
        end
        de_count = 0;
    end
    vsync_q = vsync;
    if (check_armed) begin
        check_value($sformatf("sync %0d,%0d", raster_h, raster_v),
                    16'(expected_sync(raster_h, raster_v)),
                    {13'h0000, hsync, vsync, dv_de});
        if (raster_h == vid_pkg::H_TOTAL - 1) begin
            raster_h = 0;
            raster_v = (raster_v + 1) % vid_pkg::V_TOTAL;
        end else begin
            raster_h++;
        end
    end
    if (dv_de) begin
        if (check_armed) begin
            x = de_count % vid_pkg::H_VISIBLE;
            y = de_count / vid_pkg::H_VISIBLE;
            check_value($sformatf("pixel %0d,%0d", x, y), 16'(expected_pixel(x, y)),
                        {4'h0, red, green, blue});
            if (de_count == PIXELS - 1) begin
                check_armed = 1'b0;
                check_req   = 1'b0;
            end
        end
        de_count++;
    end
end

initial begin : main
    logic [15:0] w;
    logic [15:0] got;
    logic [7:0]  st;
    int          i;
    int          count0;
    int          afails;
    clk         = 1'b0;
    reset_i     = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = 4'h0;
    bus_bytesel = 1'b0;
    bus_wdata   = 8'h00;
    rng         = 32'd91;
    tests       = 0;
    checks      = 0;
    errors      = 0;
    intr_count  = 0;
    de_count    = 0;
    raster_h    = 0;
    raster_v    = 0;
    vsync_q     = 1'b0;
    check_req   = 1'b0;
    check_armed = 1'b0;
    ref_start   = 16'h0000;
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;

    begin_test("xr_readback");
    for (i = 0; i < 16; i++) begin
        random_word(w);
        ref_pal[i] = w[11:0];                       // top nibble not stored
        write_xr(vid_pkg::XR_PALETTE_BASE + 8'(i), w);
    end
    random_word(w);
    ref_start = w;
    write_xr(vid_pkg::XR_START_ADDR, w);
    for (i = 0; i < 16; i++) begin
        read_xr(vid_pkg::XR_PALETTE_BASE + 8'(i), got);
        check_value($sformatf("palette %0d", i), {4'h0, ref_pal[i]}, got);
    end
    read_xr(vid_pkg::XR_START_ADDR, got);
    check_value("start address", ref_start, got);
    end_test();

    begin_test("vram_readback");
    fill_vram(16'h0200, 16);
    read_word(vid_pkg::REG_VRAM_WADDR, got);
    check_value("write address", 16'h0210, got);
    for (i = 0; i < 16; i++) begin
        read_vram(16'h0200 + 16'(i), got);
        check_value($sformatf("word %0d", i), ref_vram[16'h0200 + i], got);
    end
    end_test();

    begin_test("frame_image");
    ref_start = 16'h0000;
    write_xr(vid_pkg::XR_START_ADDR, ref_start);
    fill_vram(16'h0000, 128);                       // covers both later bases
    check_frame();
    end_test();

    begin_test("start_address");
    ref_start = 16'h0024;
    write_xr(vid_pkg::XR_START_ADDR, ref_start);
    check_frame();
    ref_start = 16'h005C;
    write_xr(vid_pkg::XR_START_ADDR, ref_start);
    check_frame();
    end_test();

    begin_test("interrupt");
    write_byte(vid_pkg::REG_INT, 1'b1, 8'h0F);      // clear status, mask still 0
    count0 = intr_count;
    wait_frames(2);
    check_value("pulses with mask clear", 16'd0, 16'(intr_count - count0));
    read_byte(vid_pkg::REG_INT, 1'b1, st);
    check_value("status with mask clear", 16'h0001, {8'h00, st});
    write_byte(vid_pkg::REG_INT, 1'b0, 8'h01);      // enable vblank
    read_byte(vid_pkg::REG_INT, 1'b0, st);
    check_value("mask", 16'h0001, {8'h00, st});
    count0 = intr_count;
    wait_frames(2);
    check_value("pulses while pending", 16'd0, 16'(intr_count - count0));
    for (i = 0; i < 2; i++) begin
        write_byte(vid_pkg::REG_INT, 1'b1, 8'h01);
        count0 = intr_count;
        wait_frames(2);
        check_value($sformatf("pulses after clear %0d", i), 16'd1,
                    16'(intr_count - count0));
    end
    write_byte(vid_pkg::REG_INT, 1'b0, 8'h00);
    end_test();

    afails = i_dut.i_assert.assert_failures;
    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests, checks, errors, afails);
    if (errors == 0 && afails == 0) begin
        $display("Testbench passed");
    end else begin
        $display("Testbench failed");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: verilog/reg_interface.sv
// cpu register interface
`default_nettype none
`timescale 1ns/1ns

module reg_interface (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // chip select, active low
    input  wire logic           bus_rd_nwr_i,   // 1 read, 0 write
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,  // 0 even (high) byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,     // one cycle strobe
    input  wire logic           vblank_i,
    vram_port_if.req            vram,
    xr_bus_if.ctrl              xr
);

logic               cs_n_q;         // chip select last cycle
logic               cs_start;       // first low cycle of access
logic               wr_even;
logic               wr_odd;
logic               start_wr;       // begin vram write
logic               start_rd;       // begin vram read
logic [7:0]         data_hi;        // latched even byte
vid_pkg::word_t     wr_word;        // full word on odd byte
vid_pkg::addr_t     wr_addr;        // auto increments
vid_pkg::addr_t     rd_addr;
vid_pkg::word_t     rd_buf;         // vram read buffer
vid_pkg::word_t     xr_rd;          // xr read-back
vid_pkg::word_t     rd_word;        // word shown on reads
logic               busy;           // vram access in flight
logic [3:0]         intr_mask;
logic [3:0]         intr_status;    // pending
logic [3:0]         intr_sig;
logic [3:0]         intr_clr;

assign cs_start = cs_n_q && !bus_cs_n_i;
assign wr_even  = cs_start && !bus_rd_nwr_i && !bus_bytesel_i;
assign wr_odd   = cs_start && !bus_rd_nwr_i && bus_bytesel_i;
assign wr_word  = { data_hi, bus_data_i };
assign start_wr = wr_odd && !busy && (bus_reg_num_i == vid_pkg::REG_VRAM_DATA);
assign start_rd = wr_odd && !busy && (bus_reg_num_i == vid_pkg::REG_VRAM_RADDR);
assign intr_clr = (wr_odd && bus_reg_num_i == vid_pkg::REG_INT) ? bus_data_i[3:0] : 4'h0;

always_comb begin
    intr_sig                        = 4'h0;
    intr_sig[vid_pkg::INT_VBLANK]   = vblank_i;
end

// register read mux
always_comb begin
    case (bus_reg_num_i)
        vid_pkg::REG_VRAM_WADDR:    rd_word = wr_addr;
        vid_pkg::REG_VRAM_RADDR:    rd_word = rd_addr;
        vid_pkg::REG_VRAM_RDATA:    rd_word = rd_buf;
        vid_pkg::REG_XR_ADDR:       rd_word = { 8'h00, xr.addr };
        vid_pkg::REG_XR_DATA:       rd_word = xr_rd;
        vid_pkg::REG_INT:           rd_word = { 4'h0, intr_mask, busy, 3'b000, intr_status };
        default:                    rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_q      <= 1'b1;
        busy        <= 1'b0;
        vram.sel    <= 1'b0;
        vram.wr     <= 1'b0;
        xr.wr       <= 1'b0;
        xr.addr     <= '0;
        wr_addr     <= '0;
        rd_addr     <= '0;
        intr_mask   <= 4'h0;
        intr_status <= 4'h0;
        bus_intr_o  <= 1'b0;
    end else begin
        cs_n_q      <= bus_cs_n_i;
        // strobe only on a new, enabled, not yet pending source
        bus_intr_o  <= |(intr_sig & intr_mask & ~intr_status);
        intr_status <= (intr_status | intr_sig) & ~intr_clr;
        if (wr_even && bus_reg_num_i == vid_pkg::REG_INT) begin
            intr_mask <= bus_data_i[3:0];
        end
        // finish vram access, busy drops a cycle after sel
        if (vram.sel && vram.ack) begin
            vram.sel <= 1'b0;
            vram.wr  <= 1'b0;
            if (vram.wr) begin
                wr_addr <= wr_addr + 16'd1;
            end else begin
                rd_addr <= rd_addr + 16'd1;
            end
        end else if (!vram.sel) begin
            busy <= 1'b0;
        end
        if (start_wr || start_rd) begin
            vram.sel <= 1'b1;
            vram.wr  <= start_wr;
            busy     <= 1'b1;
        end
        if (start_rd) begin
            rd_addr <= wr_word;
        end
        if (wr_odd && bus_reg_num_i == vid_pkg::REG_VRAM_WADDR) begin
            wr_addr <= wr_word;
        end
        if (wr_odd && bus_reg_num_i == vid_pkg::REG_XR_ADDR) begin
            xr.addr <= wr_word[7:0];
        end
        xr.wr <= wr_odd && (bus_reg_num_i == vid_pkg::REG_XR_DATA);
    end
end

// data path
always_ff @(posedge clk) begin
    if (wr_even) begin
        data_hi <= bus_data_i;
    end
    if (start_wr || start_rd) begin
        vram.addr  <= start_wr ? wr_addr : wr_word;
        vram.wdata <= wr_word;
    end
    if (wr_odd) begin
        xr.wdata <= wr_word;
    end
    if (vram.sel && vram.ack && !vram.wr) begin
        rd_buf <= vram.rdata;
    end
    xr_rd      <= xr.rdata;                                     // a cycle behind addr
    bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
end

endmodule

`default_nettype wire

// File: verilog/vid_main.sv
// bitmap video controller top
`default_nettype none
`timescale 1ns/1ns

module vid_main (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           bus_cs_n_i,     // register select, active low
    input  wire logic           bus_rd_nwr_i,   // 1 read, 0 write
    input  wire logic [3:0]     bus_reg_num_i,
    input  wire logic           bus_bytesel_i,  // 0 even, 1 odd byte
    input  wire logic [7:0]     bus_data_i,
    output logic      [7:0]     bus_data_o,
    output logic                bus_intr_o,
    output logic      [3:0]     red_o,
    output logic      [3:0]     green_o,
    output logic      [3:0]     blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o
);

logic               vgen_sel;       // video fetch request
vid_pkg::addr_t     vgen_addr;
vid_pkg::word_t     vgen_data;
logic [3:0]         pix_index;
vid_pkg::rgb_t      color;
vid_pkg::addr_t     start_addr;
logic               vblank_pulse;   // once per frame

xr_bus_if           xr_bus();
vram_port_if        vram_port();

reg_interface i_reg_interface (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .bus_intr_o     (bus_intr_o),
    .vblank_i       (vblank_pulse),
    .vram           (vram_port),
    .xr             (xr_bus)
);

vram_arb i_vram_arb (
    .clk            (clk),
    .vgen_sel_i     (vgen_sel),
    .vgen_addr_i    (vgen_addr),
    .vgen_data_o    (vgen_data),
    .cpu            (vram_port)
);

video_gen i_video_gen (
    .clk            (clk),
    .reset_i        (reset_i),
    .start_addr_i   (start_addr),
    .vram_sel_o     (vgen_sel),
    .vram_addr_o    (vgen_addr),
    .vram_data_i    (vgen_data),
    .pix_index_o    (pix_index),
    .color_i        (color),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o),
    .vblank_o       (vblank_pulse)
);

video_regs i_video_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .xr             (xr_bus),
    .pix_index_i    (pix_index),
    .color_o        (color),
    .start_addr_o   (start_addr)
);

endmodule

`default_nettype wire

// File: vid_main.f
common/vid_pkg.sv
common/xr_bus_if.sv
common/vram_port_if.sv
verilog/reg_interface.sv
vram/vram_arb.sv
video/video_gen.sv
video/video_regs.sv
verilog/vid_main.sv
dv/vid_main_assert.sv
dv/vid_main_tb.sv

// File: video/video_gen.sv
// raster generator
`default_nettype none
`timescale 1ns/1ns

module video_gen (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire vid_pkg::addr_t start_addr_i,   // taken at frame start
    output logic                vram_sel_o,
    output vid_pkg::addr_t      vram_addr_o,
    input  wire vid_pkg::word_t vram_data_i,
    output logic [3:0]          pix_index_o,    // to palette
    input  wire vid_pkg::rgb_t  color_i,        // palette result, next cycle
    output logic [3:0]          red_o,
    output logic [3:0]          green_o,
    output logic [3:0]          blue_o,
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                dv_de_o,
    output logic                vblank_o        // first cycle of line V_VISIBLE
);

vid_pkg::hcount_t   h_count;
vid_pkg::vcount_t   v_count;
vid_pkg::addr_t     line_addr;      // first word of this line
logic               h_last;
logic               v_last;
logic               visible;
logic               hs;
logic               vs;
logic [1:0]         phase_d1;       // nibble select, follows fetch data
logic [1:0]         de_d;           // two stage delays
logic [1:0]         hs_d;
logic [1:0]         vs_d;
vid_pkg::word_t     word_q;         // held for pixels 1..3
vid_pkg::word_t     cur_word;

assign h_last  = (h_count == vid_pkg::hcount_t'(vid_pkg::H_TOTAL - 1));
assign v_last  = (v_count == vid_pkg::vcount_t'(vid_pkg::V_TOTAL - 1));
assign visible = (h_count < vid_pkg::hcount_t'(vid_pkg::H_VISIBLE)) &&
                 (v_count < vid_pkg::vcount_t'(vid_pkg::V_VISIBLE));
assign hs      = (h_count >= vid_pkg::hcount_t'(vid_pkg::HSYNC_START)) &&
                 (h_count <  vid_pkg::hcount_t'(vid_pkg::HSYNC_END));
assign vs      = (v_count == vid_pkg::vcount_t'(vid_pkg::VSYNC_LINE));

// one fetch per 4 pixels
assign vram_sel_o  = visible && (h_count[1:0] == 2'b00);
assign vram_addr_o = line_addr + vid_pkg::addr_t'(h_count >> 2);

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count   <= '0;
        v_count   <= '0;
        line_addr <= '0;
        vblank_o  <= 1'b0;
    end else begin
        vblank_o <= h_last && (v_count == vid_pkg::vcount_t'(vid_pkg::V_VISIBLE - 1));
        if (h_last) begin
            h_count <= '0;
            if (v_last) begin
                v_count   <= '0;
                line_addr <= start_addr_i;
            end else begin
                v_count   <= v_count + 1'b1;
                line_addr <= line_addr + vid_pkg::addr_t'(vid_pkg::WORDS_PER_LINE);
            end
        end else begin
            h_count <= h_count + 1'b1;
        end
    end
end

// fresh word on phase 0, else held copy
assign cur_word = (phase_d1 == 2'd0) ? vram_data_i : word_q;

always_comb begin
    case (phase_d1)
        2'd0:    pix_index_o = cur_word[15:12];     // leftmost pixel
        2'd1:    pix_index_o = cur_word[11:8];
        2'd2:    pix_index_o = cur_word[7:4];
        default: pix_index_o = cur_word[3:0];
    endcase
end

always_ff @(posedge clk) begin
    if (phase_d1 == 2'd0) begin
        word_q <= vram_data_i;
    end
end

// align sync and enable with palette output
always_ff @(posedge clk) begin
    if (reset_i) begin
        phase_d1 <= 2'd0;
        de_d     <= 2'b00;
        hs_d     <= 2'b00;
        vs_d     <= 2'b00;
        dv_de_o  <= 1'b0;
        hsync_o  <= 1'b0;
        vsync_o  <= 1'b0;
        red_o    <= 4'h0;
        green_o  <= 4'h0;
        blue_o   <= 4'h0;
    end else begin
        phase_d1 <= h_count[1:0];
        de_d     <= { de_d[0], visible };
        hs_d     <= { hs_d[0], hs };
        vs_d     <= { vs_d[0], vs };
        dv_de_o  <= de_d[1];
        hsync_o  <= hs_d[1];
        vsync_o  <= vs_d[1];
        red_o    <= de_d[1] ? color_i.r : 4'h0;     // black in blanking
        green_o  <= de_d[1] ? color_i.g : 4'h0;
        blue_o   <= de_d[1] ? color_i.b : 4'h0;
    end
end

endmodule

`default_nettype wire

// File: video/video_regs.sv
// video configuration registers
`default_nettype none
`timescale 1ns/1ns

module video_regs (
    input  wire logic           clk,
    input  wire logic           reset_i,
    xr_bus_if.periph            xr,
    input  wire logic [3:0]     pix_index_i,
    output vid_pkg::rgb_t       color_o,        // registered lookup
    output vid_pkg::addr_t      start_addr_o
);

vid_pkg::rgb_t      palette [0:15];
logic               start_hit;
logic               pal_hit;

assign start_hit = (xr.addr == vid_pkg::XR_START_ADDR);
assign pal_hit   = (xr.addr[7:4] == vid_pkg::XR_PALETTE_BASE[7:4]);     // 0x10..0x1F

always_ff @(posedge clk) begin
    if (reset_i) begin
        start_addr_o <= '0;
        for (int i = 0; i < 16; i++) begin
            palette[i] <= '0;
        end
    end else if (xr.wr) begin
        if (start_hit) begin
            start_addr_o <= xr.wdata;
        end else if (pal_hit) begin
            palette[xr.addr[3:0]] <= vid_pkg::rgb_t'(xr.wdata[11:0]);
        end
    end
end

// pixel colour, one cycle
always_ff @(posedge clk) begin
    color_o <= palette[pix_index_i];
end

// read-back
always_comb begin
    if (start_hit) begin
        xr.rdata = start_addr_o;
    end else if (pal_hit) begin
        xr.rdata = { 4'h0, palette[xr.addr[3:0]] };
    end else begin
        xr.rdata = '0;
    end
end

endmodule

`default_nettype wire

// File: vram/vram_arb.sv
// vram array and arbiter
`default_nettype none
`timescale 1ns/1ns

module vram_arb (
    input  wire logic           clk,
    input  wire logic           vgen_sel_i,     // video fetch, always wins
    input  wire vid_pkg::addr_t vgen_addr_i,
    output vid_pkg::word_t      vgen_data_o,    // one cycle after sel
    vram_port_if.mem            cpu
);

vid_pkg::word_t     mem [0:(1 << vid_pkg::VRAM_AW)-1];     // 1k words
vid_pkg::word_t     rd_q;           // shared registered read data
logic [vid_pkg::VRAM_AW-1:0] vgen_idx;
logic [vid_pkg::VRAM_AW-1:0] cpu_idx;
logic               cpu_go;         // cpu gets this cycle

assign vgen_idx = vgen_addr_i[vid_pkg::VRAM_AW-1:0];    // upper bits ignored
assign cpu_idx  = cpu.addr[vid_pkg::VRAM_AW-1:0];

// no second service while ack is out
assign cpu_go = cpu.sel && !cpu.ack && !vgen_sel_i;

always_ff @(posedge clk) begin
    cpu.ack <= cpu_go;
    if (vgen_sel_i) begin
        rd_q <= mem[vgen_idx];
    end else if (cpu_go) begin
        if (cpu.wr) begin
            mem[cpu_idx] <= cpu.wdata;
        end
        rd_q <= mem[cpu_idx];
    end
end

assign vgen_data_o = rd_q;
assign cpu.rdata   = rd_q;          // valid in ack cycle

endmodule

`default_nettype wire
